//--- hdl/mips_pkg.sv
// MIPS core shared definitions
// Widths, opcode and function codes, instruction views and stage records
package mips_pkg;

    parameter int WORD_W     = 32;               // Data and instruction word
    parameter int REG_ADDR_W = 5;                // 32 GPRs
    parameter int ADDR_W     = 32;               // Instruction address

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // -------------------------------------------------------------------
    // Instruction formats
    // -------------------------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;                            // SPECIAL view
        i_fields_t i;                            // Immediate view
    } inst_u;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // -------------------------------------------------------------------
    // Stage records
    // -------------------------------------------------------------------
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        reg_addr_t wd;                           // Destination register
        logic      wreg;                         // Write enable
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

//--- hdl/fetch_unit.sv
// Instruction fetch
// Program counter, memory enable and fetched-slot valid flag
`timescale 1ns/1ns

module fetch_unit
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset_i,
    output logic  rom_ce_o,
    output word_t pc_o,
    output logic  inst_valid_o
);

    logic [ADDR_W-1:0] pc_q;                     // Current fetch address
    logic              ce_q;                     // Memory enable
    logic              valid_q;                  // Word on rom_data_i

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= RESET_PC;
            ce_q    <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            ce_q    <= 1'b1;                     // Rises one cycle after reset
            valid_q <= ce_q;                     // Sync memory answers next cycle
            if (ce_q) begin
                pc_q <= pc_q + 32'd4;            // Always sequential with no stalls
            end
        end
    end

    assign rom_ce_o     = ce_q;
    assign pc_o         = pc_q;
    assign inst_valid_o = valid_q;

endmodule

//--- hdl/regfile.sv
// General purpose register file
// 32 x 32, two async read ports, one write port with write-through
`timescale 1ns/1ns

module regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  wb_t       wb_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < 2**REG_ADDR_W; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;        // $zero never written
        end
    end

    // Read with bypass of a same-cycle write
    function automatic word_t read_port(input reg_addr_t addr, input wb_t wr, input word_t stored);
        if (addr == '0) begin
            return '0;                           // $zero is hardwired
        end
        if (wr.we && wr.addr == addr) begin
            return wr.data;                      // Write-through
        end
        return stored;
    endfunction

    assign rdata1_o = read_port(raddr1_i, wb_i, regs[raddr1_i]);
    assign rdata2_o = read_port(raddr2_i, wb_i, regs[raddr2_i]);

endmodule

//--- hdl/decode_unit.sv
// Instruction decode
// Opcode/funct decode, operand select with EX forwarding, ID/EX register
`timescale 1ns/1ns

module decode_unit
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  inst_u     inst_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    input  wb_t       ex_fwd_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    output id_ex_t    id_ex_o
);

    alu_op_e   alu_op;
    logic      is_imm;                           // I-type format
    logic      is_shift;                         // Shift by shamt
    word_t     imm_ext;
    word_t     rs_val;
    word_t     rt_val;
    reg_addr_t dest;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;

    // Newer EX result overrides the register file value
    function automatic word_t fwd_sel(input reg_addr_t addr, input word_t rdata, input wb_t ex);
        if (ex.we && ex.addr == addr) begin
            return ex.data;
        end
        return rdata;
    endfunction

    // -------------------------------------------------------------------
    // Operation decode
    // -------------------------------------------------------------------
    always_comb begin
        alu_op = ALU_NOP;                        // Unknown codes fall through
        case (inst_i.r.opcode)
            OP_SPECIAL: begin
                case (inst_i.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  alu_op = ALU_NOP;
        endcase
    end

    assign is_imm   = (inst_i.i.opcode != OP_SPECIAL);
    assign is_shift = !is_imm && (alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA});

    // ADDIU sign-extends, logical ops and LUI zero-extend
    assign imm_ext = (inst_i.i.opcode == OP_ADDIU) ? {{16{inst_i.i.imm[15]}}, inst_i.i.imm}
                                                   : {16'b0, inst_i.i.imm};

    // -------------------------------------------------------------------
    // Register read and operand select
    // -------------------------------------------------------------------
    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;

    assign rs_val = fwd_sel(inst_i.r.rs, rdata1_i, ex_fwd_i);
    assign rt_val = fwd_sel(inst_i.r.rt, rdata2_i, ex_fwd_i);

    assign dest = is_imm ? inst_i.i.rt : inst_i.r.rd;   // rt for I-type

    always_comb begin
        id_ex_d.alu_op = alu_op;
        id_ex_d.wd     = dest;
        id_ex_d.wreg   = inst_valid_i && (dest != '0) && (alu_op != ALU_NOP);
        if (is_shift) begin
            id_ex_d.operand_a = rt_val;                 // Shifts operate on rt
            id_ex_d.operand_b = {27'b0, inst_i.r.shamt};
        end else if (is_imm) begin
            id_ex_d.operand_a = rs_val;
            id_ex_d.operand_b = imm_ext;
        end else begin
            id_ex_d.operand_a = rs_val;
            id_ex_d.operand_b = rt_val;
        end
    end

    // ID/EX pipeline register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q <= '0;                       // Bubble with wreg low
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- hdl/execute_unit.sv
// Execute stage
// Integer ALU and EX/WB register feeding write-back
`timescale 1ns/1ns

module execute_unit
    import mips_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  id_ex_t id_ex_i,
    output wb_t    ex_fwd_o,
    output wb_t    wb_o
);

    word_t      a;
    word_t      b;
    logic [4:0] sh;                              // Shift amount
    word_t      result;
    wb_t        wb_q;

    assign a  = id_ex_i.operand_a;
    assign b  = id_ex_i.operand_b;
    assign sh = b[4:0];

    // -------------------------------------------------------------------
    // ALU
    // -------------------------------------------------------------------
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result = a + b;             // Wraps mod 2^32
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: result = a << sh;
            ALU_SRL: result = a >> sh;
            ALU_SRA: result = word_t'($signed(a) >>> sh);   // Sign fill
            ALU_LUI: result = b << 16;           // Imm to upper half
            default: result = '0;
        endcase
    end

    // Same-cycle result back to decode
    assign ex_fwd_o.we   = id_ex_i.wreg;
    assign ex_fwd_o.addr = id_ex_i.wd;
    assign ex_fwd_o.data = result;

    // EX/WB pipeline register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_fwd_o;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- hdl/mips_core.sv
// Pipelined MIPS32 integer core, ALU subset
// Fetch, decode, execute, write-back; trace port shows each write-back
`timescale 1ns/1ns

module mips_core
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     rom_data_i,
    output logic      rom_ce_o,
    output word_t     rom_addr_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    // -------------------------------------------------------------------
    // Stage interconnect
    // -------------------------------------------------------------------
    logic      inst_valid;                       // Fetch -> decode
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    id_ex_t    id_ex;                            // Decode -> execute
    wb_t       ex_fwd;                           // Execute -> decode bypass
    wb_t       wb;                               // Write-back and trace

    fetch_unit #(
        .RESET_PC     (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .rom_ce_o     (rom_ce_o),
        .pc_o         (rom_addr_o),
        .inst_valid_o (inst_valid)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_i     (wb),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    decode_unit u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid),
        .inst_i       (rom_data_i),              // Sync ROM output is the IF/ID stage
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .id_ex_o      (id_ex)
    );

    execute_unit u_execute (
        .clk      (clk),
        .reset_i  (reset_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb)
    );

    assign wb_we_o   = wb.we;
    assign wb_addr_o = wb.addr;
    assign wb_data_o = wb.data;

endmodule

//--- verification/mips_core_props.sv
// Port assertions for the MIPS core
// Quiet reset exit, no r0 write-back, sequential fetch addresses
`timescale 1ns/1ns

module mips_core_props
    import mips_pkg::*;
(
    input logic      clk,
    input logic      reset_i,
    input logic      rom_ce_i,
    input word_t     rom_addr_i,
    input logic      wb_we_i,
    input reg_addr_t wb_addr_i
);

    reset_quiet: assert property (@(posedge clk) $fell(reset_i) |-> !rom_ce_i && !wb_we_i)
        else $error("rom_ce_o or wb_we_o high in the first cycle after reset");

    no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_we_i |-> wb_addr_i != '0)
        else $error("write-back strobe with register 0 as destination");

    // Straight-line fetch with no stalls or branches
    pc_step: assert property (@(posedge clk) disable iff (reset_i)
        rom_ce_i && $past(rom_ce_i) |-> rom_addr_i == $past(rom_addr_i) + 32'd4)
        else $error("fetch address did not advance by 4");

endmodule

//--- verification/core_checker.sv
// Write-back checker for the MIPS core
// Replays each fetched word on a register model and compares the trace port
`timescale 1ns/1ns

module core_checker
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      rom_ce_i,
    input  word_t     rom_addr_i,
    input  word_t     rom_data_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_addr_i,
    input  word_t     wb_data_i,
    output int        checked_o,
    output int        mismatches_o,
    output int        other_errors_o
);

    word_t      model_regs [32];
    word_t      fetch_q [$];                        // Fetched and not yet retired
    logic [2:0] ce_hist;                            // Bit 0 is one cycle back
    logic       reset_d;
    word_t      expect_pc;

    function automatic int compare_value(input string name, input word_t expected,
                                         input word_t actual);
        if (expected !== actual) begin
            $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // -------------------------------------------------------------------
    // Reference model of the instruction subset
    // -------------------------------------------------------------------
    function automatic wb_t model_exec(input inst_u ins);
        wb_t   res;
        word_t a;
        word_t b;
        word_t imm_s;
        word_t imm_z;
        a        = model_regs[ins.r.rs];
        b        = model_regs[ins.r.rt];
        imm_s    = {{16{ins.i.imm[15]}}, ins.i.imm};
        imm_z    = {16'h0000, ins.i.imm};
        res.we   = 1'b1;
        res.addr = ins.r.rd;
        res.data = '0;
        if (ins.r.opcode == OP_SPECIAL) begin
            case (ins.r.funct)
                FN_ADDU: res.data = a + b;
                FN_SUBU: res.data = a - b;
                FN_AND:  res.data = a & b;
                FN_OR:   res.data = a | b;
                FN_XOR:  res.data = a ^ b;
                FN_NOR:  res.data = ~(a | b);
                FN_SLT:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  res.data = b << ins.r.shamt;
                FN_SRL:  res.data = b >> ins.r.shamt;
                FN_SRA:  res.data = (b >> ins.r.shamt)
                                  | ({32{b[31]}} & ~(32'hffff_ffff >> ins.r.shamt));
                default: res.we   = 1'b0;
            endcase
        end else begin
            res.addr = ins.i.rt;                    // I-type writes rt
            case (ins.i.opcode)
                OP_ADDIU: res.data = a + imm_s;
                OP_ANDI:  res.data = a & imm_z;
                OP_ORI:   res.data = a | imm_z;
                OP_XORI:  res.data = a ^ imm_z;
                OP_LUI:   res.data = {ins.i.imm, 16'h0000};
                default:  res.we   = 1'b0;
            endcase
        end
        if (res.addr == '0) begin
            res.we = 1'b0;                          // r0 stays zero
        end
        return res;
    endfunction

    always @(posedge clk) begin
        wb_t exp_wb;
        int  bad;
        int  other;
        bad   = 0;
        other = 0;
        if (reset_i) begin
            fetch_q.delete();
            ce_hist   = '0;
            expect_pc = RESET_PC;
            for (int k = 0; k < 32; k++) begin
                model_regs[k] = '0;
            end
        end else begin
            if (reset_d) begin                      // First cycle out of reset
                bad += compare_value("rom_ce_o", '0, word_t'(rom_ce_i));
                bad += compare_value("wb_we_o", '0, word_t'(wb_we_i));
            end
            if (rom_ce_i) begin
                bad += compare_value("rom_addr_o", expect_pc, rom_addr_i);
                expect_pc = expect_pc + 32'd4;
            end
            if (ce_hist[0]) begin
                fetch_q.push_back(rom_data_i);      // Word for last cycle's address
            end
            if (ce_hist[2]) begin                   // Fixed 3 cycle latency
                if (fetch_q.size() == 0) begin
                    $display("error at %0t: write-back due but no fetched word is queued",
                             $time);
                    other++;
                end else begin
                    exp_wb = model_exec(fetch_q.pop_front());
                    bad += compare_value("wb_we_o", word_t'(exp_wb.we), word_t'(wb_we_i));
                    if (exp_wb.we) begin
                        bad += compare_value("wb_addr_o", word_t'(exp_wb.addr),
                                             word_t'(wb_addr_i));
                        bad += compare_value("wb_data_o", exp_wb.data, wb_data_i);
                        model_regs[exp_wb.addr] = exp_wb.data;
                    end
                    checked_o <= checked_o + 1;
                end
            end else if (!reset_d) begin
                bad += compare_value("wb_we_o", '0, word_t'(wb_we_i));  // Empty slot
            end
            ce_hist = {ce_hist[1:0], rom_ce_i};
        end
        reset_d = reset_i;
        mismatches_o   <= mismatches_o + bad;
        other_errors_o <= other_errors_o + other;
    end

endmodule

//--- verification/tb_mips_core.sv
// Testbench for the pipelined MIPS core
// Random ALU program in a synchronous ROM model, trace checked by core_checker
`timescale 1ns/1ns

module tb_mips_core
    import mips_pkg::*;
();

    localparam word_t RESET_PC   = 32'h0000_0100;   // Nonzero start address
    localparam int    PROG_WORDS = 256;
    localparam int    RUN_INSTS  = 300;
    localparam int    TIMEOUT    = 2000;            // Cycles

    localparam logic [5:0] R_FUNCTS [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                             FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] I_OPS [5] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    logic        clk;
    logic        reset;
    word_t       rom_data;
    logic        rom_ce;
    word_t       rom_addr;
    logic        wb_we;
    reg_addr_t   wb_addr;
    word_t       wb_data;
    int          checked;
    int          mismatches;
    int          other_errors;
    int          cycles;
    int          timeouts;
    logic [31:0] seed;
    word_t       prog [PROG_WORDS];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // -------------------------------------------------------------------
    // Program mix of 60% R-type, 30% I-type and 10% unknown opcodes
    // -------------------------------------------------------------------
    task automatic build_program();
        int        pick;
        int        sel;
        r_fields_t rf;
        i_fields_t fi;
        for (int k = 0; k < PROG_WORDS; k++) begin
            seed = lcg_next(seed);
            pick = int'(seed[31:16] % 16'd100);
            seed = lcg_next(seed);                  // Fresh bits for fields
            if (pick < 60) begin
                sel       = int'(seed[15:0] % 16'd10);
                rf.opcode = OP_SPECIAL;
                rf.rs     = {2'b0, seed[18:16]};    // r0..r7 keeps hazards dense
                rf.rt     = {2'b0, seed[21:19]};
                rf.rd     = {2'b0, seed[24:22]};
                rf.shamt  = seed[29:25];
                rf.funct  = R_FUNCTS[sel];
                prog[k]   = rf;
            end else begin
                sel       = int'(seed[15:0] % 16'd5);
                fi.rs     = {2'b0, seed[18:16]};
                fi.rt     = {2'b0, seed[21:19]};
                fi.opcode = (pick < 90) ? I_OPS[sel] : seed[27:22];
                if (pick >= 90 && fi.opcode inside {OP_SPECIAL, OP_ADDIU, OP_ANDI,
                                                    OP_ORI, OP_XORI, OP_LUI}) begin
                    fi.opcode = 6'h3f;              // Force an unused opcode
                end
                seed    = lcg_next(seed);
                fi.imm  = seed[31:16];
                prog[k] = fi;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Synchronous instruction ROM with data one cycle after the address
    always @(posedge clk) begin
        if (rom_ce) begin
            rom_data <= prog[rom_addr[9:2]];
        end
    end

    mips_core #(
        .RESET_PC   (RESET_PC)
    ) uut (
        .clk        (clk),
        .reset_i    (reset),
        .rom_data_i (rom_data),
        .rom_ce_o   (rom_ce),
        .rom_addr_o (rom_addr),
        .wb_we_o    (wb_we),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data)
    );

    core_checker #(
        .RESET_PC       (RESET_PC)
    ) u_checker (
        .clk            (clk),
        .reset_i        (reset),
        .rom_ce_i       (rom_ce),
        .rom_addr_i     (rom_addr),
        .rom_data_i     (rom_data),
        .wb_we_i        (wb_we),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .checked_o      (checked),
        .mismatches_o   (mismatches),
        .other_errors_o (other_errors)
    );

    bind mips_core mips_core_props u_props (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_ce_i   (rom_ce_o),
        .rom_addr_i (rom_addr_o),
        .wb_we_i    (wb_we_o),
        .wb_addr_i  (wb_addr_o)
    );

    // -------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------
    initial begin
        reset    = 1'b1;
        rom_data = '0;
        seed     = 32'hfe31d072;
        timeouts = 0;
        build_program();
        repeat (8) @(posedge clk);                  // 8 reset cycles
        reset  <= 1'b0;
        cycles = 0;
        while (checked < RUN_INSTS && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (checked < RUN_INSTS) begin
            timeouts = 1;
            $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                     checked, RUN_INSTS, cycles);
        end
        $display("checked %0d instructions: %0d mismatches, %0d other errors, %0d timeouts",
                 checked, mismatches, other_errors, timeouts);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/mips_pkg.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mips_core.sv
verification/mips_core_props.sv
verification/core_checker.sv
verification/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MIPS core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mips_core -f src.f --Mdir obj_dir -o sim_mips_core

output=$(./obj_dir/sim_mips_core)
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
